//--- mini_mips_settings.svh
`ifndef MINI_MIPS_SETTINGS_SVH
`define MINI_MIPS_SETTINGS_SVH

// Data path and register file.
`define MM_DATA_WIDTH 32
`define MM_NUM_REGS_LOG2 5

// Instruction word and instruction memory.
`define MM_INST_WIDTH 32
`define MM_IMEM_DEPTH_LOG2 6

`endif

//--- isa_pkg.sv
`default_nettype none
`include "mini_mips_settings.svh"

package isa_pkg;

  localparam int OPCODE_WIDTH = 6;
  localparam int FUNCT_WIDTH = 6;
  localparam int IMM_WIDTH = 16;
  localparam int ALU_OP_WIDTH = 3;

  // Register field positions in the instruction word.
  localparam int RS_LSB = 21;
  localparam int RT_LSB = 16;
  localparam int RD_LSB = 11;

  typedef logic [`MM_NUM_REGS_LOG2-1:0] reg_idx_t;

  typedef enum logic [OPCODE_WIDTH-1:0] {
    OP_RTYPE = 6'h00,
    OP_BEQ   = 6'h04,
    OP_ADDI  = 6'h08
  } opcode_e;

  typedef enum logic [FUNCT_WIDTH-1:0] {
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2a
  } funct_e;

  typedef enum logic [ALU_OP_WIDTH-1:0] {
    ALU_ADD, // Zero value, so a bubble decodes as an add.
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_e;

endpackage

`default_nettype wire

//--- pipe_pkg.sv
`default_nettype none
`include "mini_mips_settings.svh"

package pipe_pkg;
  import isa_pkg::*;

  // Fetch to decode. An all-zero word is a no-op.
  typedef struct packed {
    logic [`MM_INST_WIDTH-1:0] instr;
    logic [`MM_IMEM_DEPTH_LOG2-1:0] pc;
  } if_id_t;

  // Decode to execute.
  typedef struct packed {
    logic valid;
    logic [`MM_IMEM_DEPTH_LOG2-1:0] pc;
    logic [`MM_DATA_WIDTH-1:0] rs_val;
    logic [`MM_DATA_WIDTH-1:0] rt_val;
    logic [`MM_DATA_WIDTH-1:0] imm; // Sign-extended.
    reg_idx_t dest;
    alu_op_e alu_op;
    logic alu_src_imm;
    logic reg_write;
    logic is_branch;
  } id_ex_t;

  // Execute to writeback.
  typedef struct packed {
    logic valid;
    reg_idx_t dest;
    logic [`MM_DATA_WIDTH-1:0] result;
    logic reg_write;
  } ex_wb_t;

endpackage

`default_nettype wire

//--- hazard_if.sv
`timescale 1ns/1ns
`default_nettype none
`include "mini_mips_settings.svh"

interface hazard_if;
  import isa_pkg::*;

  // Source registers read by the instruction in decode.
  reg_idx_t id_rs;
  reg_idx_t id_rt;
  logic id_uses_rs;
  logic id_uses_rt;

  // Destination and redirect from the instruction in execute.
  reg_idx_t ex_dest;
  logic ex_reg_write;
  logic branch_taken;
  logic [`MM_IMEM_DEPTH_LOG2-1:0] branch_target;

  logic stall;
  logic flush;

  modport decode (output id_rs, id_rt, id_uses_rs, id_uses_rt);
  modport execute (output ex_dest, ex_reg_write, branch_taken, branch_target);
  modport fetch (input stall, branch_taken, branch_target);
  modport hazard (
    input id_rs, id_rt, id_uses_rs, id_uses_rt, ex_dest, ex_reg_write, branch_taken,
    output stall, flush
  );

endinterface

`default_nettype wire

//--- stage_reg.sv
`timescale 1ns/1ns
`default_nettype none

module stage_reg #(
  parameter type stage_t = logic
) (
  input wire logic clk,
  input wire logic reset,
  input var bit stall,
  input var bit flush,
  input wire stage_t d,
  output stage_t q
);

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      q <= '0; // Bubble.
    end else if (!stall) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

//--- instr_fetch.sv
`timescale 1ns/1ns
`default_nettype none
`include "mini_mips_settings.svh"

module instr_fetch (
  input wire logic clk,
  input wire logic reset,
  input wire logic run,
  input wire logic load_en,
  input wire logic [`MM_IMEM_DEPTH_LOG2-1:0] load_addr,
  input wire logic [`MM_INST_WIDTH-1:0] load_data,
  hazard_if.fetch hz,
  output pipe_pkg::if_id_t if_id
);

  logic [`MM_INST_WIDTH-1:0] imem [2**`MM_IMEM_DEPTH_LOG2];
  logic [`MM_IMEM_DEPTH_LOG2-1:0] pc;

  // Words never loaded read back as no-ops.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**`MM_IMEM_DEPTH_LOG2; i++) begin
        imem[i] <= '0;
      end
    end else if (load_en) begin
      imem[load_addr] <= load_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (hz.branch_taken) begin
      pc <= hz.branch_target; // Redirect wins over stall.
    end else if (run && !hz.stall) begin
      pc <= pc + 1'b1;
    end
  end

  always_comb begin
    if_id = '0; // Bubble while idle.
    if (run) begin
      if_id.instr = imem[pc];
      if_id.pc = pc;
    end
  end

endmodule

`default_nettype wire

//--- decode_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "mini_mips_settings.svh"

module decode_unit (
  input wire logic clk,
  input wire logic reset,
  input wire pipe_pkg::if_id_t if_id,
  input wire pipe_pkg::ex_wb_t wb,
  hazard_if.decode hz,
  output pipe_pkg::id_ex_t id_ex
);
  import isa_pkg::*;

  logic [`MM_DATA_WIDTH-1:0] regs [2**`MM_NUM_REGS_LOG2];
  opcode_e opcode;
  funct_e funct;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;
  logic [IMM_WIDTH-1:0] imm;
  logic wb_write;
  logic uses_rs;
  logic uses_rt;

  assign opcode = opcode_e'(if_id.instr[`MM_INST_WIDTH-1 -: OPCODE_WIDTH]);
  assign funct = funct_e'(if_id.instr[FUNCT_WIDTH-1:0]);
  assign rs = if_id.instr[RS_LSB +: `MM_NUM_REGS_LOG2];
  assign rt = if_id.instr[RT_LSB +: `MM_NUM_REGS_LOG2];
  assign rd = if_id.instr[RD_LSB +: `MM_NUM_REGS_LOG2];
  assign imm = if_id.instr[IMM_WIDTH-1:0];

  assign wb_write = wb.valid && wb.reg_write && (wb.dest != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**`MM_NUM_REGS_LOG2; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_write) begin
      regs[wb.dest] <= wb.result;
    end
  end

  // Same-cycle write is visible to the read. r0 is always zero.
  function automatic logic [`MM_DATA_WIDTH-1:0] read_reg(input reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end
    if (wb_write && (wb.dest == idx)) begin
      return wb.result;
    end
    return regs[idx];
  endfunction

  always_comb begin
    id_ex = '0;
    uses_rs = 1'b0;
    uses_rt = 1'b0;
    case (opcode)
      OP_RTYPE: begin
        id_ex.valid = 1'b1;
        id_ex.dest = rd;
        id_ex.reg_write = 1'b1;
        uses_rs = 1'b1;
        uses_rt = 1'b1;
        case (funct)
          FN_ADD: id_ex.alu_op = ALU_ADD;
          FN_SUB: id_ex.alu_op = ALU_SUB;
          FN_AND: id_ex.alu_op = ALU_AND;
          FN_OR: id_ex.alu_op = ALU_OR;
          FN_SLT: id_ex.alu_op = ALU_SLT;
          default: id_ex.valid = 1'b0; // Includes the no-op word.
        endcase
      end
      OP_ADDI: begin
        id_ex.valid = 1'b1;
        id_ex.dest = rt;
        id_ex.alu_src_imm = 1'b1;
        id_ex.reg_write = 1'b1;
        uses_rs = 1'b1;
      end
      OP_BEQ: begin
        id_ex.valid = 1'b1;
        id_ex.alu_op = ALU_SUB;
        id_ex.is_branch = 1'b1;
        uses_rs = 1'b1;
        uses_rt = 1'b1;
      end
      default: ;
    endcase
    if (!id_ex.valid) begin
      id_ex = '0;
      uses_rs = 1'b0;
      uses_rt = 1'b0;
    end else begin
      id_ex.pc = if_id.pc;
      id_ex.rs_val = read_reg(rs);
      id_ex.rt_val = read_reg(rt);
      id_ex.imm = {{(`MM_DATA_WIDTH-IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm};
    end
  end

  assign hz.id_rs = rs;
  assign hz.id_rt = rt;
  assign hz.id_uses_rs = uses_rs;
  assign hz.id_uses_rt = uses_rt;

endmodule

`default_nettype wire

//--- execute_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "mini_mips_settings.svh"

module execute_unit (
  input wire pipe_pkg::id_ex_t id_ex,
  hazard_if.execute hz,
  output pipe_pkg::ex_wb_t ex_wb
);
  import isa_pkg::*;

  logic [`MM_DATA_WIDTH-1:0] op_b;
  logic [`MM_DATA_WIDTH-1:0] result;
  logic write_en;

  assign op_b = id_ex.alu_src_imm ? id_ex.imm : id_ex.rt_val;

  always_comb begin
    result = '0;
    case (id_ex.alu_op)
      ALU_ADD: result = id_ex.rs_val + op_b;
      ALU_SUB: result = id_ex.rs_val - op_b;
      ALU_AND: result = id_ex.rs_val & op_b;
      ALU_OR: result = id_ex.rs_val | op_b;
      ALU_SLT: result[0] = $signed(id_ex.rs_val) < $signed(op_b);
      default: result = '0;
    endcase
  end

  // No write to r0 leaves this stage.
  assign write_en = id_ex.valid && id_ex.reg_write && (id_ex.dest != '0);

  always_comb begin
    ex_wb = '0;
    ex_wb.valid = id_ex.valid && !id_ex.is_branch;
    ex_wb.dest = id_ex.dest;
    ex_wb.result = result;
    ex_wb.reg_write = write_en;
  end

  assign hz.ex_dest = id_ex.dest;
  assign hz.ex_reg_write = write_en;
  assign hz.branch_taken = id_ex.valid && id_ex.is_branch && (id_ex.rs_val == id_ex.rt_val);
  assign hz.branch_target = id_ex.pc + 1'b1 + id_ex.imm[`MM_IMEM_DEPTH_LOG2-1:0]; // Word address.

endmodule

`default_nettype wire

//--- hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
  hazard_if.hazard hz
);

  logic rs_match;
  logic rt_match;
  logic raw;

  assign rs_match = hz.id_uses_rs && (hz.id_rs == hz.ex_dest);
  assign rt_match = hz.id_uses_rt && (hz.id_rt == hz.ex_dest);

  // Writer in execute has no result yet. One cycle later it is in writeback.
  assign raw = hz.ex_reg_write && (rs_match || rt_match);

  // A taken branch squashes the dependent instruction anyway.
  assign hz.flush = hz.branch_taken;
  assign hz.stall = raw && !hz.branch_taken;

endmodule

`default_nettype wire

//--- mini_mips_core.sv
`timescale 1ns/1ns
`default_nettype none
`include "mini_mips_settings.svh"

module mini_mips_core (
  input wire logic clk,
  input wire logic reset,
  input wire logic run,
  input wire logic load_en,
  input wire logic [`MM_IMEM_DEPTH_LOG2-1:0] load_addr,
  input wire logic [`MM_INST_WIDTH-1:0] load_data,
  output logic wb_valid,
  output isa_pkg::reg_idx_t wb_reg,
  output logic [`MM_DATA_WIDTH-1:0] wb_data
);
  import pipe_pkg::*;

  if_id_t if_id_d;
  if_id_t if_id_q;
  id_ex_t id_ex_d;
  id_ex_t id_ex_q;
  ex_wb_t ex_wb_d;
  ex_wb_t ex_wb_q;
  logic id_ex_clear;

  hazard_if hz ();

  // A stall turns the decode output into a bubble.
  assign id_ex_clear = hz.flush || hz.stall;

  instr_fetch fetch_i (
    .clk(clk),
    .reset(reset),
    .run(run),
    .load_en(load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .hz(hz),
    .if_id(if_id_d)
  );

  stage_reg #(.stage_t(if_id_t)) if_id_reg_i (
    .clk(clk),
    .reset(reset),
    .stall(hz.stall),
    .flush(hz.flush),
    .d(if_id_d),
    .q(if_id_q)
  );

  decode_unit decode_i (
    .clk(clk),
    .reset(reset),
    .if_id(if_id_q),
    .wb(ex_wb_q),
    .hz(hz),
    .id_ex(id_ex_d)
  );

  stage_reg #(.stage_t(id_ex_t)) id_ex_reg_i (
    .clk(clk),
    .reset(reset),
    .stall(1'b0),
    .flush(id_ex_clear),
    .d(id_ex_d),
    .q(id_ex_q)
  );

  execute_unit execute_i (
    .id_ex(id_ex_q),
    .hz(hz),
    .ex_wb(ex_wb_d)
  );

  stage_reg #(.stage_t(ex_wb_t)) ex_wb_reg_i (
    .clk(clk),
    .reset(reset),
    .stall(1'b0),
    .flush(1'b0),
    .d(ex_wb_d),
    .q(ex_wb_q)
  );

  hazard_unit hazard_i (
    .hz(hz)
  );

  assign wb_valid = ex_wb_q.valid && ex_wb_q.reg_write;
  assign wb_reg = ex_wb_q.dest;
  assign wb_data = ex_wb_q.result;

endmodule

`default_nettype wire

//--- tb_mini_mips.sv
`timescale 1ns/1ns
`default_nettype none
`include "mini_mips_settings.svh"

module tb_mini_mips;
  import isa_pkg::*;

  localparam int NUM_INSTR = 20;
  localparam int NUM_WRITES = 15;
  localparam int IDLE_CYCLES = 8;
  localparam int WB_TIMEOUT = 20;
  localparam int QUIET_CYCLES = 30; // Ends before the pc wraps back to 0.

  logic clk;
  logic reset;
  logic run;
  logic load_en;
  logic [`MM_IMEM_DEPTH_LOG2-1:0] load_addr;
  logic [`MM_INST_WIDTH-1:0] load_data;
  logic wb_valid;
  reg_idx_t wb_reg;
  logic [`MM_DATA_WIDTH-1:0] wb_data;

  logic [`MM_INST_WIDTH-1:0] program_words [NUM_INSTR];
  reg_idx_t exp_reg [NUM_WRITES];
  logic [`MM_DATA_WIDTH-1:0] exp_data [NUM_WRITES];

  int value_errors;
  int other_errors;

  mini_mips_core dut_i (
    .clk(clk),
    .reset(reset),
    .run(run),
    .load_en(load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .wb_valid(wb_valid),
    .wb_reg(wb_reg),
    .wb_data(wb_data)
  );

  always #5 clk = ~clk;

  function automatic logic [`MM_INST_WIDTH-1:0] encode_rtype(
    input funct_e fn, input reg_idx_t rd, input reg_idx_t rs, input reg_idx_t rt
  );
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [`MM_INST_WIDTH-1:0] encode_addi(
    input reg_idx_t rt, input reg_idx_t rs, input int imm
  );
    return {OP_ADDI, rs, rt, imm[15:0]};
  endfunction

  function automatic logic [`MM_INST_WIDTH-1:0] encode_beq(
    input reg_idx_t rs, input reg_idx_t rt, input int offset
  );
    return {OP_BEQ, rs, rt, offset[15:0]}; // Target is pc + 1 + offset.
  endfunction

  task automatic expect_write(input int idx, input reg_idx_t r, input logic [31:0] d);
    exp_reg[idx] = r;
    exp_data[idx] = d;
  endtask

  task automatic build_tables();
    program_words[0] = encode_addi(5'd1, 5'd0, 5);
    program_words[1] = encode_addi(5'd2, 5'd0, -3);
    program_words[2] = encode_rtype(FN_ADD, 5'd3, 5'd1, 5'd2); // Stalls on r2.
    program_words[3] = encode_rtype(FN_SUB, 5'd4, 5'd2, 5'd1);
    program_words[4] = encode_rtype(FN_AND, 5'd5, 5'd3, 5'd4);
    program_words[5] = encode_rtype(FN_OR, 5'd6, 5'd3, 5'd4);
    program_words[6] = encode_rtype(FN_SLT, 5'd7, 5'd2, 5'd1);
    program_words[7] = encode_rtype(FN_SLT, 5'd8, 5'd1, 5'd2);
    program_words[8] = encode_addi(5'd0, 5'd1, 7); // Write to r0 is dropped.
    program_words[9] = encode_rtype(FN_ADD, 5'd9, 5'd0, 5'd1);
    program_words[10] = encode_addi(5'd10, 5'd0, -1);
    program_words[11] = encode_rtype(FN_ADD, 5'd11, 5'd10, 5'd10);
    program_words[12] = encode_beq(5'd1, 5'd9, 2); // Taken, to word 15.
    program_words[13] = encode_addi(5'd12, 5'd0, 1);
    program_words[14] = encode_addi(5'd13, 5'd0, 2);
    program_words[15] = encode_addi(5'd14, 5'd0, 9);
    program_words[16] = encode_addi(5'd15, 5'd14, 1);
    program_words[17] = encode_beq(5'd1, 5'd2, 1); // Not taken.
    program_words[18] = encode_rtype(FN_ADD, 5'd16, 5'd15, 5'd15);
    program_words[19] = encode_rtype(FN_SUB, 5'd17, 5'd0, 5'd16);

    // Register values of the sequential program, in retire order.
    expect_write(0, 5'd1, 32'h0000_0005);
    expect_write(1, 5'd2, 32'hffff_fffd);
    expect_write(2, 5'd3, 32'h0000_0002);
    expect_write(3, 5'd4, 32'hffff_fff8);
    expect_write(4, 5'd5, 32'h0000_0000);
    expect_write(5, 5'd6, 32'hffff_fffa);
    expect_write(6, 5'd7, 32'h0000_0001); // Signed -3 < 5.
    expect_write(7, 5'd8, 32'h0000_0000);
    expect_write(8, 5'd9, 32'h0000_0005);
    expect_write(9, 5'd10, 32'hffff_ffff);
    expect_write(10, 5'd11, 32'hffff_fffe); // Wraps around.
    expect_write(11, 5'd14, 32'h0000_0009);
    expect_write(12, 5'd15, 32'h0000_000a);
    expect_write(13, 5'd16, 32'h0000_0014);
    expect_write(14, 5'd17, 32'hffff_ffec);
  endtask

  task automatic check_valid(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s = %b, expected %b", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_data(
    input string name, input logic [`MM_DATA_WIDTH-1:0] got,
    input logic [`MM_DATA_WIDTH-1:0] exp
  );
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s = %h, expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < NUM_INSTR; i++) begin
      @(posedge clk);
      #1;
      load_en = 1'b1;
      load_addr = i[`MM_IMEM_DEPTH_LOG2-1:0];
      load_data = program_words[i];
      @(negedge clk);
      check_valid("wb_valid", wb_valid, 1'b0);
    end
    @(posedge clk);
    #1;
    load_en = 1'b0;
  endtask

  task automatic wait_for_write(input int idx, output bit timed_out);
    timed_out = 1'b1;
    for (int cycles = 0; cycles < WB_TIMEOUT; cycles++) begin
      @(negedge clk);
      if (wb_valid) begin
        timed_out = 1'b0;
        break;
      end
    end
    if (timed_out) begin
      $display("Timeout at %0t ns: write %0d to r%0d never appeared on the writeback port",
               $time, idx, exp_reg[idx]);
      other_errors++;
    end
  endtask

  task automatic check_quiet();
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(negedge clk);
      if (wb_valid) begin
        $display("Unexpected writeback at %0t ns after the program ended: r%0d = %h",
                 $time, wb_reg, wb_data);
        other_errors++;
      end
    end
  endtask

  initial begin
    bit timed_out;
    clk = 1'b0;
    reset = 1'b1;
    run = 1'b0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    value_errors = 0;
    other_errors = 0;
    timed_out = 1'b0;
    build_tables();

    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    for (int i = 0; i < IDLE_CYCLES; i++) begin
      @(negedge clk);
      check_valid("wb_valid", wb_valid, 1'b0);
    end
    load_program();

    @(posedge clk);
    #1;
    run = 1'b1;

    for (int i = 0; i < NUM_WRITES && !timed_out; i++) begin
      wait_for_write(i, timed_out);
      if (!timed_out) begin
        check_reg($sformatf("wb_reg (write %0d)", i), wb_reg, exp_reg[i]);
        check_data($sformatf("wb_data (write %0d)", i), wb_data, exp_data[i]);
      end
    end
    if (!timed_out) begin
      check_quiet();
    end

    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mini_mips.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
hazard_if.sv
stage_reg.sv
instr_fetch.sv
decode_unit.sv
execute_unit.sv
hazard_unit.sv
mini_mips_core.sv
tb_mini_mips.sv

//--- Bender.yml
package:
  name: mini_mips

sources:
  - include_dirs:
      - .
    files:
      - isa_pkg.sv
      - pipe_pkg.sv
      - hazard_if.sv
      - stage_reg.sv
      - instr_fetch.sv
      - decode_unit.sv
      - execute_unit.sv
      - hazard_unit.sv
      - mini_mips_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mini_mips.sv
